// ==== dv/clint_lite_props.sv ====
`default_nettype none

module clint_lite_props
  import irq_pkg::*;
(
  input wire             clock,
  input wire             aresetn,
  input wire irq_vec_t   pending_i,  // arbiter pending vector
  input wire             valid_i,    // arbiter valid level
  input wire irq_cause_t cause_i     // arbiter cause code
);

  timeunit 1ns;
  timeprecision 1ps;

  // valid is just the or of the vector
  valid_low_when_idle: assert property (
    @(posedge clock) disable iff (!aresetn)
    (pending_i == '0) |-> !valid_i
  ) else $error("irq_valid_o high with an empty pending vector");

  // machine external always wins
  mei_wins: assert property (
    @(posedge clock) disable iff (!aresetn)
    pending_i[IRQ_MEIP_BIT] |-> (cause_i == CAUSE_MEI)
  ) else $error("MEI pending but cause is not CAUSE_MEI");

  // idle code is zero
  cause_zero_when_idle: assert property (
    @(posedge clock) disable iff (!aresetn)
    !valid_i |-> (cause_i == '0)
  ) else $error("irq_cause_o nonzero while irq_valid_o is low");

endmodule

// one checker per arbiter instance
bind irq_arbiter clint_lite_props i_props (
  .clock     ( clock         ),
  .aresetn   ( aresetn       ),
  .pending_i ( irq_pending_o ),
  .valid_i   ( irq_valid_o   ),
  .cause_i   ( irq_cause_o   )
);

`default_nettype wire

// ==== dv/clint_lite_tb.sv ====
`default_nettype none

module clint_lite_tb
  import irq_pkg::*;
  import clint_map_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  // tests take about 350 cycles in total, limit leaves ample margin
  localparam int unsigned TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] RNG_SEED       = 32'h57a8_1abd;
  localparam int unsigned MASK_ROUNDS    = 30;

  logic       clock;
  logic       aresetn;
  logic       cfg_valid;
  cfg_addr_t  cfg_addr;
  cfg_data_t  cfg_data;
  ext_irq_t   interrupts;
  mtime_t     mtime;
  irq_vec_t   irq_pending;
  logic       irq_valid;
  irq_cause_t irq_cause;

  int          error_count;
  int          check_count;
  int unsigned cycle_count = 0;  // free running, for the timeout
  logic [31:0] rng_state;

  clint_lite_top i_dut (
    .clock         ( clock       ),
    .aresetn       ( aresetn     ),
    .cfg_valid_i   ( cfg_valid   ),
    .cfg_addr_i    ( cfg_addr    ),
    .cfg_data_i    ( cfg_data    ),
    .interrupts_i  ( interrupts  ),
    .mtime_o       ( mtime       ),
    .irq_pending_o ( irq_pending ),
    .irq_valid_o   ( irq_valid   ),
    .irq_cause_o   ( irq_cause   )
  );

  always #4 clock = ~clock;  // 8 ns period

  // run limit
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout: simulation ran %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  task automatic expect_equal(input string test_name, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
               test_name, what, expected, actual);
    end
  endtask

  // one beat, lands in the DUT at the second edge
  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
    @(posedge clock);
    cfg_valid <= 1'b1;
    cfg_addr  <= addr;
    cfg_data  <= data;
    @(posedge clock);
    cfg_valid <= 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clock);
  endtask

  task automatic reset_defaults();
    @(negedge clock);  // first cycle out of reset
    expect_equal("reset_defaults", "mtime_o", 64'd0, mtime);
    expect_equal("reset_defaults", "irq_valid_o", 64'd0, 64'(irq_valid));
    expect_equal("reset_defaults", "irq_pending_o", 64'd0, 64'(irq_pending));
    expect_equal("reset_defaults", "irq_cause_o", 64'd0, 64'(irq_cause));
    for (int i = 0; i < 5; i++) begin
      @(negedge clock);
      expect_equal("reset_defaults", "mtime_o step", 64'(i + 1), mtime);  // cycles since reset
    end
    @(posedge clock);
    interrupts <= '1;  // all lines up, masks still closed
    wait_cycles(4);
    @(negedge clock);
    expect_equal("reset_defaults", "masked irq_pending_o", 64'd0, 64'(irq_pending));
    expect_equal("reset_defaults", "masked irq_valid_o", 64'd0, 64'(irq_valid));
    @(posedge clock);
    interrupts <= '0;
  endtask

  task automatic timer_fires_at_compare();
    mtime_t cmp;
    @(negedge clock);
    cmp = mtime + 64'd40;  // hi half is zero this early
    cfg_write(MTIMECMP_HI_ADDR, 32'h0);
    cfg_write(MTIMECMP_LO_ADDR, cmp[31:0]);
    @(negedge clock);
    while (mtime + 64'd2 < cmp) begin
      expect_equal("timer_fires_at_compare", "MTI before compare", 64'd0,
                   64'(irq_pending[IRQ_MTIP_BIT]));
      @(negedge clock);
    end
    while (mtime < cmp + 64'd3) begin
      @(negedge clock);
    end
    expect_equal("timer_fires_at_compare", "MTI after compare", 64'd1,
                 64'(irq_pending[IRQ_MTIP_BIT]));
    expect_equal("timer_fires_at_compare", "irq_valid_o", 64'd1, 64'(irq_valid));
    expect_equal("timer_fires_at_compare", "irq_cause_o", 64'(CAUSE_MTI), 64'(irq_cause));
  endtask

  task automatic timer_off_by_high_half();
    cfg_write(MTIMECMP_HI_ADDR, 32'hffff_ffff);  // compare far in the future
    wait_cycles(4);
    @(negedge clock);
    expect_equal("timer_off_by_high_half", "MTI", 64'd0, 64'(irq_pending[IRQ_MTIP_BIT]));
    expect_equal("timer_off_by_high_half", "irq_valid_o", 64'd0, 64'(irq_valid));
  endtask

  task automatic masking_rounds();
    ext_irq_t  lines;
    cfg_data_t mdata;
    cfg_data_t sdata;
    logic      exp_meip;
    logic      exp_seip;
    for (int r = 0; r < MASK_ROUNDS; r++) begin
      rng_state = xorshift32(rng_state);
      lines     = rng_state[EXT_IRQ_W-1:0];
      rng_state = xorshift32(rng_state);
      mdata     = rng_state;  // upper bits random too, must be ignored
      rng_state = xorshift32(rng_state);
      sdata     = rng_state;
      exp_meip  = |(lines & mdata[EXT_IRQ_W-1:0]);
      exp_seip  = |(lines & sdata[EXT_IRQ_W-1:0]);
      cfg_write(MINTEN_ADDR, mdata);
      cfg_write(SINTEN_ADDR, sdata);
      interrupts <= lines;
      wait_cycles(4);
      @(negedge clock);
      expect_equal("masking_rounds", "MEI", 64'(exp_meip), 64'(irq_pending[IRQ_MEIP_BIT]));
      expect_equal("masking_rounds", "SEI", 64'(exp_seip), 64'(irq_pending[IRQ_SEIP_BIT]));
    end
    @(posedge clock);
    interrupts <= '0;
  endtask

  task automatic priority_order();
    cfg_write(MINTEN_ADDR, 32'h1);  // line 0 to machine
    cfg_write(SINTEN_ADDR, 32'h2);  // line 1 to supervisor
    interrupts <= 4'b0011;
    cfg_write(MTIMECMP_LO_ADDR, 32'h0);
    cfg_write(MTIMECMP_HI_ADDR, 32'h0);  // compare zero, timer fires at once
    wait_cycles(4);
    @(negedge clock);
    expect_equal("priority_order", "all pending", 64'd7, 64'(irq_pending));
    expect_equal("priority_order", "cause with MEI", 64'(CAUSE_MEI), 64'(irq_cause));
    cfg_write(MINTEN_ADDR, 32'h0);
    wait_cycles(4);
    @(negedge clock);
    expect_equal("priority_order", "MEI cleared", 64'd0, 64'(irq_pending[IRQ_MEIP_BIT]));
    expect_equal("priority_order", "cause with MTI", 64'(CAUSE_MTI), 64'(irq_cause));
    cfg_write(MTIMECMP_HI_ADDR, 32'hffff_ffff);
    wait_cycles(4);
    @(negedge clock);
    expect_equal("priority_order", "MTI cleared", 64'd0, 64'(irq_pending[IRQ_MTIP_BIT]));
    expect_equal("priority_order", "SEI left", 64'd1, 64'(irq_pending[IRQ_SEIP_BIT]));
    expect_equal("priority_order", "cause with SEI", 64'(CAUSE_SEI), 64'(irq_cause));
    @(posedge clock);
    interrupts <= '0;
  endtask

  initial begin
    clock       = 1'b0;
    aresetn     = 1'b0;
    cfg_valid   = 1'b0;
    cfg_addr    = '0;
    cfg_data    = '0;
    interrupts  = '0;
    error_count = 0;
    check_count = 0;
    rng_state   = RNG_SEED;
    repeat (10) @(posedge clock);
    aresetn <= 1'b1;  // released on an edge, counter starts next cycle
    reset_defaults();
    timer_fires_at_compare();
    timer_off_by_high_half();
    masking_rounds();
    priority_order();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/clint_lite_top.sv ====
`default_nettype none

module clint_lite_top
  import irq_pkg::*;
  import clint_map_pkg::*;
(
  input  wire             clock,
  input  wire             aresetn,
  input  wire             cfg_valid_i,    // shared by timer and gate
  input  wire cfg_addr_t  cfg_addr_i,
  input  wire cfg_data_t  cfg_data_i,
  input  wire ext_irq_t   interrupts_i,
  output wire mtime_t     mtime_o,
  output wire irq_vec_t   irq_pending_o,
  output wire             irq_valid_o,
  output wire irq_cause_t irq_cause_o
);

  wire mtip;  // timer level into the arbiter
  wire meip;  // machine external level
  wire seip;  // supervisor external level

  // each source decodes its own part of the register map
  mtimer i_mtimer (
    .clock       ( clock       ),
    .aresetn     ( aresetn     ),
    .cfg_valid_i ( cfg_valid_i ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_data_i  ( cfg_data_i  ),
    .mtime_o     ( mtime_o     ),
    .mtip_o      ( mtip        )
  );

  ext_irq_gate i_ext_irq_gate (
    .clock        ( clock        ),
    .aresetn      ( aresetn      ),
    .cfg_valid_i  ( cfg_valid_i  ),
    .cfg_addr_i   ( cfg_addr_i   ),
    .cfg_data_i   ( cfg_data_i   ),
    .interrupts_i ( interrupts_i ),
    .meip_o       ( meip         ),
    .seip_o       ( seip         )
  );

  // two register stages from any source to the pending vector
  irq_arbiter i_irq_arbiter (
    .clock         ( clock         ),
    .aresetn       ( aresetn       ),
    .mtip_i        ( mtip          ),
    .meip_i        ( meip          ),
    .seip_i        ( seip          ),
    .irq_pending_o ( irq_pending_o ),
    .irq_valid_o   ( irq_valid_o   ),
    .irq_cause_o   ( irq_cause_o   )
  );

endmodule

`default_nettype wire

// ==== logic/clint_map_pkg.sv ====
`default_nettype none

package clint_map_pkg;

  localparam int unsigned CFG_ADDR_W = 4;   // word address into the register map
  localparam int unsigned CFG_DATA_W = 32;  // one write beat

  typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;  // register select
  typedef logic [CFG_DATA_W-1:0] cfg_data_t;  // write payload

  // timer compare, split into two words
  localparam cfg_addr_t MTIMECMP_LO_ADDR = 4'd0;  // bits 31:0 of mtimecmp
  localparam cfg_addr_t MTIMECMP_HI_ADDR = 4'd1;  // bits 63:32 of mtimecmp

  // external interrupt enables, low EXT_IRQ_W bits are used
  localparam cfg_addr_t MINTEN_ADDR      = 4'd2;  // machine mode mask
  localparam cfg_addr_t SINTEN_ADDR      = 4'd3;  // supervisor mode mask

  // addresses 4..15 are unmapped and writes there are dropped

endpackage

`default_nettype wire

// ==== logic/ext_irq_gate.sv ====
`default_nettype none

module ext_irq_gate
  import irq_pkg::*;
  import clint_map_pkg::*;
(
  input  wire            clock,
  input  wire            aresetn,
  input  wire            cfg_valid_i,
  input  wire cfg_addr_t cfg_addr_i,
  input  wire cfg_data_t cfg_data_i,
  input  wire ext_irq_t  interrupts_i,  // level lines from peripherals
  output logic           meip_o,        // machine external pending
  output logic           seip_o         // supervisor external pending
);

  ext_irq_t minten_q;     // machine enable mask
  ext_irq_t sinten_q;     // supervisor enable mask
  logic     wr_minten;
  logic     wr_sinten;
  ext_irq_t m_active;     // lines enabled for machine mode
  ext_irq_t s_active;     // lines enabled for supervisor mode
  logic     meip_q;
  logic     seip_q;

  assign wr_minten = cfg_valid_i && (cfg_addr_i == MINTEN_ADDR);
  assign wr_sinten = cfg_valid_i && (cfg_addr_i == SINTEN_ADDR);

  // masks start closed, upper write data bits are ignored
  always_ff @(posedge clock or negedge aresetn) begin
    if (!aresetn) begin
      minten_q <= '0;
      sinten_q <= '0;
    end else begin
      if (wr_minten) begin
        minten_q <= cfg_data_i[EXT_IRQ_W-1:0];
      end
      if (wr_sinten) begin
        sinten_q <= cfg_data_i[EXT_IRQ_W-1:0];
      end
    end
  end

  assign m_active = interrupts_i & minten_q;
  assign s_active = interrupts_i & sinten_q;

  // a line may be routed to both modes at once
  always_ff @(posedge clock or negedge aresetn) begin
    if (!aresetn) begin
      meip_q <= 1'b0;
      seip_q <= 1'b0;
    end else begin
      meip_q <= |m_active;  // or-reduce to one level
      seip_q <= |s_active;
    end
  end

  assign meip_o = meip_q;
  assign seip_o = seip_q;

endmodule

`default_nettype wire

// ==== logic/irq_arbiter.sv ====
`default_nettype none

module irq_arbiter
  import irq_pkg::*;
(
  input  wire         clock,
  input  wire         aresetn,
  input  wire         mtip_i,         // from mtimer
  input  wire         meip_i,         // from ext_irq_gate
  input  wire         seip_i,         // from ext_irq_gate
  output irq_vec_t    irq_pending_o,  // one bit per source
  output logic        irq_valid_o,    // anything pending
  output irq_cause_t  irq_cause_o     // winner, zero when idle
);

  irq_vec_t   pending_d;
  irq_vec_t   pending_q;
  logic       valid_d;
  logic       valid_q;
  irq_cause_t cause_d;
  irq_cause_t cause_q;

  // place each source at its fixed bit
  always_comb begin
    pending_d               = '0;
    pending_d[IRQ_SEIP_BIT] = seip_i;
    pending_d[IRQ_MTIP_BIT] = mtip_i;
    pending_d[IRQ_MEIP_BIT] = meip_i;
  end

  assign valid_d = |pending_d;

  // fixed priority MEI > MTI > SEI
  always_comb begin
    cause_d = '0;  // idle code
    if (pending_d[IRQ_MEIP_BIT]) begin
      cause_d = CAUSE_MEI;
    end else if (pending_d[IRQ_MTIP_BIT]) begin
      cause_d = CAUSE_MTI;
    end else if (pending_d[IRQ_SEIP_BIT]) begin
      cause_d = CAUSE_SEI;
    end
  end

  // vector, valid and cause are sampled together so they always agree
  always_ff @(posedge clock or negedge aresetn) begin
    if (!aresetn) begin
      pending_q <= '0;
      valid_q   <= 1'b0;
      cause_q   <= '0;
    end else begin
      pending_q <= pending_d;
      valid_q   <= valid_d;
      cause_q   <= cause_d;
    end
  end

  assign irq_pending_o = pending_q;
  assign irq_valid_o   = valid_q;
  assign irq_cause_o   = cause_q;

endmodule

`default_nettype wire

// ==== logic/irq_pkg.sv ====
`default_nettype none

package irq_pkg;

  localparam int unsigned EXT_IRQ_W  = 4;   // level sensitive lines from peripherals
  localparam int unsigned MTIME_W    = 64;  // machine time width
  localparam int unsigned IRQ_VEC_W  = 3;   // seip, mtip, meip
  localparam int unsigned IRQ_CAUSE_W = 4;  // enough for cause 11

  typedef logic [EXT_IRQ_W-1:0]   ext_irq_t;    // lines and their enable masks
  typedef logic [MTIME_W-1:0]     mtime_t;      // time and compare value
  typedef logic [IRQ_VEC_W-1:0]   irq_vec_t;    // pending vector
  typedef logic [IRQ_CAUSE_W-1:0] irq_cause_t;  // mcause style code

  // pending vector layout
  localparam int unsigned IRQ_SEIP_BIT = 0;  // supervisor external
  localparam int unsigned IRQ_MTIP_BIT = 1;  // machine timer
  localparam int unsigned IRQ_MEIP_BIT = 2;  // machine external

  // interrupt cause codes as in the privileged spec
  localparam irq_cause_t CAUSE_MEI = 4'd11;  // highest priority
  localparam irq_cause_t CAUSE_MTI = 4'd7;
  localparam irq_cause_t CAUSE_SEI = 4'd9;   // lowest of the three

endpackage

`default_nettype wire

// ==== logic/mtimer.sv ====
`default_nettype none

module mtimer
  import irq_pkg::*;
  import clint_map_pkg::*;
(
  input  wire            clock,
  input  wire            aresetn,
  input  wire            cfg_valid_i,  // write strobe, no stall
  input  wire cfg_addr_t cfg_addr_i,
  input  wire cfg_data_t cfg_data_i,
  output mtime_t         mtime_o,      // free running time
  output logic           mtip_o        // machine timer pending
);

  mtime_t    mtime_q;      // running counter
  cfg_data_t cmp_lo_q;     // low compare word
  cfg_data_t cmp_hi_q;     // high compare word
  mtime_t    mtimecmp;     // both halves joined
  logic      wr_cmp_lo;    // write hits low word
  logic      wr_cmp_hi;    // write hits high word
  logic      mtip_q;

  // address decode, only the two compare words belong here
  assign wr_cmp_lo = cfg_valid_i && (cfg_addr_i == MTIMECMP_LO_ADDR);
  assign wr_cmp_hi = cfg_valid_i && (cfg_addr_i == MTIMECMP_HI_ADDR);

  assign mtimecmp = {cmp_hi_q, cmp_lo_q};

  // time starts at zero on the first cycle out of reset
  always_ff @(posedge clock or negedge aresetn) begin
    if (!aresetn) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 1'b1;  // wraps after 2^64 cycles
    end
  end

  // compare halves, all ones keeps the timer quiet until programmed
  always_ff @(posedge clock or negedge aresetn) begin
    if (!aresetn) begin
      cmp_lo_q <= '1;
      cmp_hi_q <= '1;
    end else begin
      if (wr_cmp_lo) begin
        cmp_lo_q <= cfg_data_i;
      end
      if (wr_cmp_hi) begin
        cmp_hi_q <= cfg_data_i;  // independent of the low word
      end
    end
  end

  // level output, stays up while time is at or past compare
  // software clears it by moving the compare value ahead
  always_ff @(posedge clock or negedge aresetn) begin
    if (!aresetn) begin
      mtip_q <= 1'b0;
    end else begin
      mtip_q <= (mtime_q >= mtimecmp);  // one cycle behind the compare
    end
  end

  assign mtime_o = mtime_q;
  assign mtip_o  = mtip_q;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the clint_lite testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
  -f sim.f \
  --top-module clint_lite_tb \
  -Mdir "$BUILD_DIR" \
  -o clint_lite_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/clint_lite_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  echo "failure reported, see $LOG"
  exit 1
fi

exit 0

// ==== sim.f ====
logic/clint_map_pkg.sv
logic/irq_pkg.sv
logic/mtimer.sv
logic/ext_irq_gate.sv
logic/irq_arbiter.sv
logic/clint_lite_top.sv
dv/clint_lite_props.sv
dv/clint_lite_tb.sv
